// File: tb.f
+incdir+src
src/mc_pkg.sv
src/link_dispatch.sv
src/tile_dmem.sv
src/link_return.sv
src/mc_array_top.sv
bench/clock_gen.sv
bench/mc_checker.sv
bench/mc_tb.sv

// File: run.sh
#!/bin/sh
# Build the tile array testbench with Verilator, run it and scan the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
  -f tb.f \
  --top-module mc_tb \
  -o mc_sim

./obj_dir/mc_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run.sh: testbench reported failure"
  exit 1
fi

echo "run.sh: testbench finished without failure"
exit 0

// File: bench/mc_tb.sv
// testbench top for the tile array
// drives LFSR-based request sequences into the DUT, lets the checker
// compare responses and bounds the run with a cycle limit
`timescale 1ns/1ps
`default_nettype none

`include "mc_consts.svh"

module mc_tb;

  localparam int ALL_WORDS   = `MC_NUM_TILES * `MC_DMEM_WORDS;
  localparam int X_VALUES    = 1 << `MC_X_FIELD_WIDTH;
  localparam int IDLE_CYCLES = 16;
  localparam int AMO_REQS    = 200;
  localparam int ERR_WORDS   = 8;
  localparam int ERR_REQS    = (X_VALUES - `MC_NUM_TILES) * ERR_WORDS
                               + `MC_NUM_TILES * ERR_WORDS;
  localparam int MIX_REQS    = 300;
  // each mixed request may be followed by up to 3 idle cycles
  localparam int MIX_CYCLES  = MIX_REQS * 4;
  localparam int NUM_TESTS   = 5;
  localparam int DRAIN_CYCLES = 8;
  localparam int TIMEOUT_CYCLES = IDLE_CYCLES + ALL_WORDS + ALL_WORDS + AMO_REQS
                                  + ERR_REQS + MIX_CYCLES + 3 * NUM_TESTS + 100;

  logic                         clk;
  logic                         reset;
  logic                         req_v_i;
  mc_pkg::mc_req_s              req_i;
  logic                         rsp_v_o;
  mc_pkg::mc_rsp_s              rsp_o;
  logic                         test_end;
  logic [3:0]                   test_num;
  logic                         final_check;
  logic [31:0]                  pending;
  logic [31:0]                  checks;
  logic [31:0]                  errors;
  logic [15:0]                  lfsr_state;
  logic [`MC_LOAD_ID_WIDTH-1:0] next_id;
  int                           cycle_count = 0;

  clock_gen u_clk (
    .clk_o   (clk),
    .reset_o (reset)
  );

  mc_array_top u_dut (
    .clk     (clk),
    .reset   (reset),
    .req_v_i (req_v_i),
    .req_i   (req_i),
    .rsp_v_o (rsp_v_o),
    .rsp_o   (rsp_o)
  );

  mc_checker u_chk (
    .clk           (clk),
    .reset         (reset),
    .req_v_i       (req_v_i),
    .req_i         (req_i),
    .rsp_v_i       (rsp_v_o),
    .rsp_i         (rsp_o),
    .test_end_i    (test_end),
    .test_num_i    (test_num),
    .final_check_i (final_check),
    .pending_o     (pending),
    .checks_o      (checks),
    .errors_o      (errors)
  );

  // galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // opcode 3 is unused so it folds onto a load
  function automatic logic [1:0] pick_op(input logic [31:0] r);
    if (r[1:0] == 2'd3) begin
      return mc_pkg::op_load;
    end
    return r[1:0];
  endfunction

  task automatic send_req(input logic [1:0] op, input logic [31:0] x,
                          input logic [31:0] word, input logic [31:0] data);
    req_i.op      = mc_pkg::mc_op_e'(op);
    req_i.addr.x  = x[`MC_X_FIELD_WIDTH-1:0];
    req_i.addr.word = word[`MC_DMEM_ADDR_WIDTH-1:0];
    req_i.data    = data;
    req_i.load_id = next_id;
    next_id       = next_id + 1'b1;
    req_v_i       = 1'b1;
    @(posedge clk);
    #2;
    req_v_i       = 1'b0;
  endtask

  task automatic idle(input int n);
    req_v_i = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic finish_test(input int n);
    int waited;
    waited = 0;
    while (pending != 0 && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      #2;
      waited++;
    end
    test_num = 4'(n);
    test_end = 1'b1;
    @(posedge clk);
    #2;
    test_end = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] r;
    req_v_i     = 1'b0;
    req_i       = '0;
    test_end    = 1'b0;
    test_num    = '0;
    final_check = 1'b0;
    next_id     = '0;
    lfsr_state  = 16'd27189;
    @(posedge reset);
    @(posedge clk);
    #2;

    // checker flags any response seen while idle
    idle(IDLE_CYCLES);
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      for (int w = 0; w < `MC_DMEM_WORDS; w++) begin
        send_req(mc_pkg::op_store, t, w, take_bits(32));
      end
    end
    finish_test(1);

    for (int w = 0; w < `MC_DMEM_WORDS; w++) begin
      for (int t = 0; t < `MC_NUM_TILES; t++) begin
        send_req(mc_pkg::op_load, t, w, take_bits(32));
      end
    end
    finish_test(2);

    // narrow word range so amoadds hit the same words again
    for (int i = 0; i < AMO_REQS; i++) begin
      r = take_bits(1);
      send_req(r[0] ? mc_pkg::op_amoadd : mc_pkg::op_load, take_bits(2),
               take_bits(3), take_bits(32));
    end
    finish_test(3);

    for (int x = `MC_NUM_TILES; x < X_VALUES; x++) begin
      for (int w = 0; w < ERR_WORDS; w++) begin
        send_req(pick_op(take_bits(2)), x, w, take_bits(32));
      end
    end
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      for (int w = 0; w < ERR_WORDS; w++) begin
        send_req(mc_pkg::op_load, t, w, take_bits(32));
      end
    end
    finish_test(4);

    for (int i = 0; i < MIX_REQS; i++) begin
      send_req(pick_op(take_bits(2)), take_bits(`MC_X_FIELD_WIDTH),
               take_bits(`MC_DMEM_ADDR_WIDTH), take_bits(32));
      r = take_bits(2);
      idle(int'(r));
    end
    finish_test(5);

    final_check = 1'b1;
    @(posedge clk);
    #2;
    final_check = 1'b0;
    $display("%0d responses checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/mc_checker.sv
// response checker for the tile array
// keeps a model of every tile memory, queues the expected response of
// each request and compares it against the response link
`timescale 1ns/1ps
`default_nettype none

`include "mc_consts.svh"

module mc_checker (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   req_v_i,
  input  wire mc_pkg::mc_req_s  req_i,
  input  wire                   rsp_v_i,
  input  wire mc_pkg::mc_rsp_s  rsp_i,
  input  wire                   test_end_i,
  input  wire [3:0]             test_num_i,
  input  wire                   final_check_i,
  output logic [31:0]           pending_o,
  output logic [31:0]           checks_o,
  output logic [31:0]           errors_o
);

  localparam int TILE_SEL_WIDTH = $clog2(`MC_NUM_TILES);
  // request sampled at edge n shows up at the edge n+3 sample
  localparam int LATENCY = 3;

  logic [`MC_DATA_WIDTH-1:0] model_mem [`MC_NUM_TILES][`MC_DMEM_WORDS];
  mc_pkg::mc_rsp_s           exp_q [$];
  int                        sent_q [$];
  int                        cyc = 0;
  int                        checks = 0;
  int                        errors = 0;
  int                        test_checks = 0;
  int                        test_errors = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  function automatic string test_name(input logic [3:0] n);
    case (n)
      4'd1:    return "reset and fill";
      4'd2:    return "back-to-back loads";
      4'd3:    return "amoadd with loads";
      4'd4:    return "out-of-range x";
      4'd5:    return "random mix";
      default: return "unnamed";
    endcase
  endfunction

  // builds the expected response and updates the model
  function automatic mc_pkg::mc_rsp_s apply_to_model(input mc_pkg::mc_req_s req);
    mc_pkg::mc_rsp_s            rsp;
    logic [TILE_SEL_WIDTH-1:0]  tile;
    logic [`MC_DATA_WIDTH-1:0]  old;
    rsp.data    = '0;
    rsp.load_id = req.load_id;
    rsp.err     = 1'b0;
    if (int'(req.addr.x) >= `MC_NUM_TILES) begin
      rsp.err = 1'b1;
    end else begin
      tile = req.addr.x[TILE_SEL_WIDTH-1:0];
      old  = model_mem[tile][req.addr.word];
      case (req.op)
        mc_pkg::op_store: begin
          model_mem[tile][req.addr.word] = req.data;
        end
        mc_pkg::op_amoadd: begin
          rsp.data = old;
          model_mem[tile][req.addr.word] = old + req.data;
        end
        default: begin
          rsp.data = old;
        end
      endcase
    end
    return rsp;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    if (exp !== act) begin
      $display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_response();
    mc_pkg::mc_rsp_s exp;
    int              sent;
    int              lat;
    if (exp_q.size() == 0) begin
      $display("response at time %0t with load_id %0d arrived with no request outstanding",
               $time, rsp_i.load_id);
      errors++;
      test_errors++;
    end else begin
      exp  = exp_q.pop_front();
      sent = sent_q.pop_front();
      checks++;
      test_checks++;
      compare_field("rsp_o.data", exp.data, rsp_i.data);
      compare_field("rsp_o.load_id", 32'(exp.load_id), 32'(rsp_i.load_id));
      compare_field("rsp_o.err", 32'(exp.err), 32'(rsp_i.err));
      lat = cyc - sent;
      if (lat != LATENCY) begin
        $display("response at time %0t came %0d cycles after its request, not %0d",
                 $time, lat, LATENCY);
        errors++;
        test_errors++;
      end
    end
  endtask

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset) begin
      // pop before push so a stray response is never matched to a new request
      if (rsp_v_i) begin
        check_response();
      end
      if (req_v_i) begin
        exp_q.push_back(apply_to_model(req_i));
        sent_q.push_back(cyc);
      end
    end
    if (test_end_i) begin
      $display("test %0d (%s) done: %0d responses checked, %0d errors",
               test_num_i, test_name(test_num_i), test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    if (final_check_i && exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      errors++;
    end
    pending_o = exp_q.size();
  end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
// testbench clock and reset source
// 40 ns clock, active low reset held for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD_NS = 20;
  localparam int RESET_CYCLES   = 8;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // release just after an edge, like the other inputs
  initial begin
    reset_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    reset_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: src/mc_array_top.sv
// remote-memory tile array top level
// dispatcher, one row of tile memories and the response returner
// three register stages from request to response
`timescale 1ns/1ps
`default_nettype none

`include "mc_consts.svh"

module mc_array_top (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   req_v_i,
  input  wire mc_pkg::mc_req_s  req_i,
  output logic                  rsp_v_o,
  output mc_pkg::mc_rsp_s       rsp_o
);

  logic [`MC_NUM_TILES-1:0]              tile_v;
  mc_pkg::mc_tile_req_s                  tile_req;
  logic                                  err_v;
  logic [`MC_LOAD_ID_WIDTH-1:0]          err_load_id;
  logic [`MC_NUM_TILES-1:0]              tile_rsp_v;
  mc_pkg::mc_rsp_s [`MC_NUM_TILES-1:0]   tile_rsp;

  link_dispatch u_dispatch (
    .clk           (clk),
    .reset         (reset),
    .req_v_i       (req_v_i),
    .req_i         (req_i),
    .tile_v_o      (tile_v),
    .tile_req_o    (tile_req),
    .err_v_o       (err_v),
    .err_load_id_o (err_load_id)
  );

  // tiles share the request bus, each has its own valid
  for (genvar t = 0; t < `MC_NUM_TILES; t++) begin : g_tile
    tile_dmem u_tile (
      .clk     (clk),
      .reset   (reset),
      .v_i     (tile_v[t]),
      .req_i   (tile_req),
      .rsp_v_o (tile_rsp_v[t]),
      .rsp_o   (tile_rsp[t])
    );
  end

  link_return u_return (
    .clk           (clk),
    .reset         (reset),
    .tile_rsp_v_i  (tile_rsp_v),
    .tile_rsp_i    (tile_rsp),
    .err_v_i       (err_v),
    .err_load_id_i (err_load_id),
    .rsp_v_o       (rsp_v_o),
    .rsp_o         (rsp_o)
  );

endmodule

`default_nettype wire

// File: src/link_return.sv
// response return path
// lines the dispatcher error up with the tile responses and merges
// the single valid source onto the registered response link
`timescale 1ns/1ps
`default_nettype none

`include "mc_consts.svh"

module link_return (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire [`MC_NUM_TILES-1:0]                tile_rsp_v_i,
  input  wire mc_pkg::mc_rsp_s [`MC_NUM_TILES-1:0] tile_rsp_i,
  input  wire                                    err_v_i,
  input  wire [`MC_LOAD_ID_WIDTH-1:0]            err_load_id_i,
  output logic                                   rsp_v_o,
  output mc_pkg::mc_rsp_s                        rsp_o
);

  logic                         err_v_r;
  logic [`MC_LOAD_ID_WIDTH-1:0] err_load_id_r;
  logic                         rsp_v_n;
  mc_pkg::mc_rsp_s              rsp_n;

  // error skips the tile stage, so hold it one cycle
  always_ff @(posedge clk) begin
    if (!reset) begin
      err_v_r <= 1'b0;
    end else begin
      err_v_r <= err_v_i;
    end
  end

  always_ff @(posedge clk) begin
    err_load_id_r <= err_load_id_i;
  end

  // at most one source valid per cycle
  always_comb begin
    rsp_v_n = err_v_r || (|tile_rsp_v_i);
    rsp_n   = '{data: '0, load_id: err_load_id_r, err: err_v_r};
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      if (tile_rsp_v_i[t]) begin
        rsp_n = tile_rsp_i[t];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      rsp_v_o <= 1'b0;
    end else begin
      rsp_v_o <= rsp_v_n;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_v_n) begin
      rsp_o <= rsp_n;
    end
  end

endmodule

`default_nettype wire

// File: src/tile_dmem.sv
// tile data memory
// executes load, store and atomic add on a word-addressed memory and
// registers the response on the same edge as the access
`timescale 1ns/1ps
`default_nettype none

`include "mc_consts.svh"

module tile_dmem (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        v_i,
  input  wire mc_pkg::mc_tile_req_s  req_i,
  output logic                       rsp_v_o,
  output mc_pkg::mc_rsp_s            rsp_o
);

  logic [`MC_DATA_WIDTH-1:0] mem [`MC_DMEM_WORDS];
  logic [`MC_DATA_WIDTH-1:0] old_word;
  logic [`MC_DATA_WIDTH-1:0] new_word;
  logic                      wr_en;

  assign old_word = mem[req_i.word];

  always_comb begin
    case (req_i.op)
      mc_pkg::op_store: begin
        wr_en    = 1'b1;
        new_word = req_i.data;
      end
      mc_pkg::op_amoadd: begin
        wr_en    = 1'b1;
        // wraps modulo 2**32
        new_word = old_word + req_i.data;
      end
      default: begin
        wr_en    = 1'b0;
        new_word = old_word;
      end
    endcase
  end

  // read-modify-write in one edge
  always_ff @(posedge clk) begin
    if (v_i && wr_en) begin
      mem[req_i.word] <= new_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      rsp_v_o <= 1'b0;
    end else begin
      rsp_v_o <= v_i;
    end
  end

  // stores answer with zero, others with the old word
  always_ff @(posedge clk) begin
    if (v_i) begin
      rsp_o.data    <= (req_i.op == mc_pkg::op_store) ? '0 : old_word;
      rsp_o.load_id <= req_i.load_id;
      rsp_o.err     <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: src/link_dispatch.sv
// request dispatcher for the tile row
// registers each host request, strips the x field and raises the valid
// of the tile it names, or flags an error when no such tile exists
`timescale 1ns/1ps
`default_nettype none

`include "mc_consts.svh"

module link_dispatch (
  input  wire                                 clk,
  input  wire                                 reset,
  input  wire                                 req_v_i,
  input  wire mc_pkg::mc_req_s                req_i,
  output logic [`MC_NUM_TILES-1:0]            tile_v_o,
  output mc_pkg::mc_tile_req_s                tile_req_o,
  output logic                                err_v_o,
  output logic [`MC_LOAD_ID_WIDTH-1:0]        err_load_id_o
);

  logic [`MC_NUM_TILES-1:0] tile_v_n;
  logic                     in_range;
  mc_pkg::mc_tile_req_s     tile_req_n;
  mc_pkg::mc_tile_req_s     tile_req_r;

  // only place the x range is tested
  assign in_range = int'(req_i.addr.x) < `MC_NUM_TILES;

  // one-hot tile select
  always_comb begin
    for (int t = 0; t < `MC_NUM_TILES; t++) begin
      tile_v_n[t] = req_v_i && (int'(req_i.addr.x) == t);
    end
  end

  assign tile_req_n = '{
    op:      req_i.op,
    word:    req_i.addr.word,
    data:    req_i.data,
    load_id: req_i.load_id
  };

  always_ff @(posedge clk) begin
    if (!reset) begin
      tile_v_o <= '0;
      err_v_o  <= 1'b0;
    end else begin
      tile_v_o <= tile_v_n;
      err_v_o  <= req_v_i && !in_range;
    end
  end

  // payload only moves with a request
  always_ff @(posedge clk) begin
    if (req_v_i) begin
      tile_req_r <= tile_req_n;
    end
  end

  assign tile_req_o    = tile_req_r;
  assign err_load_id_o = tile_req_r.load_id;

endmodule

`default_nettype wire

// File: src/mc_pkg.sv
// shared types for the remote-memory tile array
// opcodes and the host request, tile request and response packets
`default_nettype none

`include "mc_consts.svh"

package mc_pkg;

  typedef enum logic [1:0] {
    op_load   = 2'd0,
    op_store  = 2'd1,
    op_amoadd = 2'd2
  } mc_op_e;

  // x picks the tile, word indexes its memory
  typedef struct packed {
    logic [`MC_X_FIELD_WIDTH-1:0]   x;
    logic [`MC_DMEM_ADDR_WIDTH-1:0] word;
  } mc_addr_s;

  // request as it arrives from the host
  typedef struct packed {
    mc_op_e                       op;
    mc_addr_s                     addr;
    logic [`MC_DATA_WIDTH-1:0]    data;
    logic [`MC_LOAD_ID_WIDTH-1:0] load_id;
  } mc_req_s;

  // request after the x field is stripped
  typedef struct packed {
    mc_op_e                         op;
    logic [`MC_DMEM_ADDR_WIDTH-1:0] word;
    logic [`MC_DATA_WIDTH-1:0]      data;
    logic [`MC_LOAD_ID_WIDTH-1:0]   load_id;
  } mc_tile_req_s;

  typedef struct packed {
    logic [`MC_DATA_WIDTH-1:0]    data;
    logic [`MC_LOAD_ID_WIDTH-1:0] load_id;
    logic                         err;
  } mc_rsp_s;

endpackage

`default_nettype wire

// File: src/mc_consts.svh
// size constants for the remote-memory tile array
// tile count, address field widths, data width and tag width
`ifndef MC_CONSTS_SVH
`define MC_CONSTS_SVH

// number of tiles in the row, at most 2**MC_X_FIELD_WIDTH
`define MC_NUM_TILES 4

// x coordinate at the top of the request address
`define MC_X_FIELD_WIDTH 3

// word address inside one tile
`define MC_DMEM_ADDR_WIDTH 6

// words per tile memory
`define MC_DMEM_WORDS (1 << `MC_DMEM_ADDR_WIDTH)

`define MC_DATA_WIDTH 32

// tag returned with every response
`define MC_LOAD_ID_WIDTH 4

`endif
